/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

    // pixel and line positions share one width
    localparam int COORD_W = 11;
    localparam int CHAN_W  = 4;

    typedef logic [COORD_W-1:0] coord_t;

    // red in the top nibble, then green, then blue
    typedef logic [3*CHAN_W-1:0] rgb_t;

    // driven whenever de is low
    localparam rgb_t RGB_BLACK = '0;

endpackage

`default_nettype wire

/* source/score_pkg.sv */
`default_nettype none

package score_pkg;

    localparam int NUM_DIGITS = 4;
    localparam int GLYPH_SIZE = 10;
    localparam int SCORE_MAX  = 9999;

    typedef logic [13:0] score_t;

    // 0 to 9 are digits, anything else draws nothing
    typedef logic [3:0] digit_idx_t;

    localparam digit_idx_t DIGIT_BLANK = 4'd10;

    // element 0 is the most significant digit
    typedef digit_idx_t digit_vec_t [NUM_DIGITS];

    // bit 9 is the leftmost column
    typedef logic [GLYPH_SIZE-1:0] glyph_row_t;

endpackage

`default_nettype wire

/* source/video_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface video_if;

    video_pkg::coord_t x;
    video_pkg::coord_t y;
    logic              de;
    // active-high levels
    logic              hsync;
    logic              vsync;

    modport source (output x, y, de, hsync, vsync);

    modport sink (input x, y, de, hsync, vsync);

endinterface

`default_nettype wire

/* source/video_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 160,
    parameter int H_FRONT  = 8,
    parameter int H_SYNC   = 16,
    parameter int H_TOTAL  = 192,
    parameter int V_ACTIVE = 40,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_TOTAL  = 46
) (
    input wire      clk,
    input wire      arst_n,
    video_if.source vid
);

    localparam video_pkg::coord_t H_LAST   = video_pkg::coord_t'(H_TOTAL - 1);
    localparam video_pkg::coord_t V_LAST   = video_pkg::coord_t'(V_TOTAL - 1);
    localparam video_pkg::coord_t H_DE_END = video_pkg::coord_t'(H_ACTIVE);
    localparam video_pkg::coord_t V_DE_END = video_pkg::coord_t'(V_ACTIVE);
    localparam video_pkg::coord_t HS_START = video_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam video_pkg::coord_t HS_END   = video_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam video_pkg::coord_t VS_START = video_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam video_pkg::coord_t VS_END   = video_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    video_pkg::coord_t x_cnt;
    video_pkg::coord_t y_cnt;

    // y steps once per line wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == H_LAST) begin
            x_cnt <= '0;
            if (y_cnt == V_LAST) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    assign vid.x     = x_cnt;
    assign vid.y     = y_cnt;
    assign vid.de    = (x_cnt < H_DE_END) && (y_cnt < V_DE_END);
    assign vid.hsync = (x_cnt >= HS_START) && (x_cnt < HS_END);
    assign vid.vsync = (y_cnt >= VS_START) && (y_cnt < VS_END);

    // porch settings must keep the sync pulse inside horizontal blanking
    hsync_outside_de: assert property (
        @(posedge clk) disable iff (!arst_n) !(vid.hsync && vid.de)
    );

endmodule

`default_nettype wire

/* source/score_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module score_latch (
    input wire                    clk,
    input wire                    arst_n,
    input wire score_pkg::score_t value,
    input wire                    load,
    input wire                    frame_start,
    output score_pkg::digit_vec_t digits
);

    localparam int SCORE_W = $bits(score_pkg::score_t);
    localparam int BCD_W   = 4 * score_pkg::NUM_DIGITS;
    localparam logic [3:0] BIT_LAST = 4'(SCORE_W - 1);

    // shows a single "0"
    localparam score_pkg::digit_vec_t RESET_DIGITS = '{
        score_pkg::DIGIT_BLANK, score_pkg::DIGIT_BLANK, score_pkg::DIGIT_BLANK, 4'd0
    };

    typedef enum logic {
        ST_IDLE,
        ST_CONV
    } state_t;

    state_t                state;
    score_pkg::score_t     shift;
    logic [BCD_W-1:0]      bcd;
    logic [BCD_W-1:0]      bcd_adj;
    logic [BCD_W-1:0]      bcd_next;
    logic [3:0]            bit_cnt;
    logic                  overrange;
    logic                  lead_zero;
    score_pkg::digit_idx_t nib;
    score_pkg::digit_vec_t conv_digits;
    score_pkg::digit_vec_t pending;

    // add 3 to every nibble above 4 before the shift
    always_comb begin
        for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
            bcd_adj[4*i +: 4] = (bcd[4*i +: 4] > 4'd4) ? bcd[4*i +: 4] + 4'd3 : bcd[4*i +: 4];
        end
    end

    assign bcd_next = {bcd_adj[BCD_W-2:0], shift[SCORE_W-1]};

    always_comb begin
        lead_zero = 1'b1;
        for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
            nib = bcd_next[BCD_W-4-4*i +: 4];
            // last digit stays visible even when zero
            lead_zero = lead_zero && (nib == '0) && (i < score_pkg::NUM_DIGITS - 1);
            conv_digits[i] = (overrange || lead_zero) ? score_pkg::DIGIT_BLANK : nib;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            pending <= RESET_DIGITS;
            digits  <= RESET_DIGITS;
        end else begin
            if (load) begin
                state <= ST_CONV;
            end else if ((state == ST_CONV) && (bit_cnt == BIT_LAST)) begin
                state   <= ST_IDLE;
                pending <= conv_digits;
            end
            if (frame_start) begin
                digits <= pending;
            end
        end
    end

    // a new load restarts the conversion
    always_ff @(posedge clk) begin
        if (load) begin
            shift     <= value;
            bcd       <= '0;
            bit_cnt   <= '0;
            overrange <= value > score_pkg::score_t'(score_pkg::SCORE_MAX);
        end else if (state == ST_CONV) begin
            shift   <= shift << 1;
            bcd     <= bcd_next;
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    for (genvar i = 0; i < score_pkg::NUM_DIGITS; i++) begin : g_digit_legal
        digit_legal: assert property (
            @(posedge clk) disable iff (!arst_n)
            (digits[i] <= 4'd9) || (digits[i] == score_pkg::DIGIT_BLANK)
        );
    end

endmodule

`default_nettype wire

/* source/digit_glyph_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_glyph_rom (
    input wire score_pkg::digit_idx_t idx,
    input wire [3:0]                  row,
    output score_pkg::glyph_row_t     bits
);

    // 10 by 10 patterns, drawn at 3x they give the 30 by 30 digits
    localparam score_pkg::glyph_row_t GLYPHS [10][score_pkg::GLYPH_SIZE] = '{
        '{10'b0011111100,
          10'b0111111110,
          10'b1100001111,
          10'b1100011111,
          10'b1100111011,
          10'b1101110011,
          10'b1111100011,
          10'b1111000011,
          10'b0111111110,
          10'b0011111100},
        '{10'b0000111000,
          10'b0011111000,
          10'b0011111000,
          10'b0000011000,
          10'b0000011000,
          10'b0000011000,
          10'b0000011000,
          10'b0000011000,
          10'b1111111111,
          10'b1111111111},
        '{10'b1111111100,
          10'b1111111110,
          10'b0000000111,
          10'b0000000111,
          10'b0011111110,
          10'b0111111100,
          10'b1110000000,
          10'b1100000000,
          10'b1111111111,
          10'b1111111111},
        '{10'b1111111100,
          10'b1111111110,
          10'b0000001111,
          10'b0000001111,
          10'b0001111110,
          10'b0001111110,
          10'b0000001111,
          10'b0000001111,
          10'b1111111110,
          10'b1111111100},
        '{10'b0011000000,
          10'b0011001100,
          10'b0111001100,
          10'b0110001100,
          10'b1110001100,
          10'b1100001100,
          10'b1111111111,
          10'b1111111111,
          10'b0000001100,
          10'b0000001100},
        '{10'b1111111111,
          10'b1111111111,
          10'b1100000000,
          10'b1100000000,
          10'b1111111110,
          10'b1111111110,
          10'b0000000111,
          10'b0000000111,
          10'b1111111110,
          10'b1111111100},
        '{10'b0011111110,
          10'b0111111110,
          10'b1111000000,
          10'b1110000000,
          10'b1111111100,
          10'b1111111110,
          10'b1100000111,
          10'b1100000111,
          10'b0111111110,
          10'b0011111100},
        '{10'b1111111111,
          10'b1111111111,
          10'b0000000011,
          10'b0000000111,
          10'b0000001110,
          10'b0000011100,
          10'b0000111000,
          10'b0001110000,
          10'b0011100000,
          10'b0111000000},
        '{10'b0011111100,
          10'b0111111110,
          10'b1110000111,
          10'b1110000111,
          10'b0111111110,
          10'b0111111110,
          10'b1110000111,
          10'b1110000111,
          10'b0111111110,
          10'b0011111100},
        '{10'b0011111100,
          10'b0111111110,
          10'b1100000011,
          10'b1100000011,
          10'b0111111111,
          10'b0011111111,
          10'b0000000011,
          10'b0000000111,
          10'b0111111110,
          10'b0111111100}
    };

    // blank index and rows past the glyph read as empty
    always_comb begin
        if ((idx < score_pkg::DIGIT_BLANK) && (row < 4'(score_pkg::GLYPH_SIZE))) begin
            bits = GLYPHS[idx][row];
        end else begin
            bits = '0;
        end
    end

endmodule

`default_nettype wire

/* source/digit_overlay.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_overlay #(
    parameter int              ORIGIN_X = 8,
    parameter int              ORIGIN_Y = 4,
    parameter int              SCALE    = 3,
    parameter video_pkg::rgb_t FG_RGB   = 12'hF80,
    parameter video_pkg::rgb_t BG_RGB   = 12'h000
) (
    input wire                        clk,
    input wire                        arst_n,
    video_if.sink                     vid,
    input wire score_pkg::digit_vec_t digits,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output video_pkg::rgb_t           rgb
);

    localparam int CELL_PX = score_pkg::GLYPH_SIZE * SCALE;
    localparam int SUB_W   = (SCALE > 1) ? $clog2(SCALE) : 1;
    localparam int DIG_W   = $clog2(score_pkg::NUM_DIGITS + 1);
    localparam video_pkg::coord_t BOX_X0 = video_pkg::coord_t'(ORIGIN_X);
    localparam video_pkg::coord_t BOX_X1 =
        video_pkg::coord_t'(ORIGIN_X + score_pkg::NUM_DIGITS * CELL_PX);
    localparam video_pkg::coord_t BOX_Y0 = video_pkg::coord_t'(ORIGIN_Y);
    localparam video_pkg::coord_t BOX_Y1 = video_pkg::coord_t'(ORIGIN_Y + CELL_PX);
    localparam logic [SUB_W-1:0] SUB_LAST  = SUB_W'(SCALE - 1);
    localparam logic [3:0]       CELL_LAST = 4'(score_pkg::GLYPH_SIZE - 1);
    localparam logic [DIG_W-1:0] DIG_END   = DIG_W'(score_pkg::NUM_DIGITS);

    // stage-1 registers double as the step counters of the previous pixel
    logic [SUB_W-1:0]      h_sub;
    logic [SUB_W-1:0]      h_sub_nxt;
    logic [3:0]            h_col;
    logic [3:0]            h_col_nxt;
    logic [DIG_W-1:0]      h_dig;
    logic [DIG_W-1:0]      h_dig_nxt;
    logic [SUB_W-1:0]      v_sub;
    logic [SUB_W-1:0]      v_sub_nxt;
    logic [3:0]            v_row;
    logic [3:0]            v_row_nxt;
    logic                  in_box;
    score_pkg::digit_idx_t idx_nxt;
    logic                  s1_in;
    score_pkg::digit_idx_t s1_idx;
    logic                  s1_de;
    logic                  s1_hs;
    logic                  s1_vs;
    score_pkg::glyph_row_t glyph_bits;
    logic                  lit;

    // x advances by one every cycle, so each step follows the last pixel
    always_comb begin
        h_sub_nxt = h_sub + 1'b1;
        h_col_nxt = h_col;
        h_dig_nxt = h_dig;
        if (vid.x == BOX_X0) begin
            h_sub_nxt = '0;
            h_col_nxt = '0;
            h_dig_nxt = '0;
        end else if (h_sub == SUB_LAST) begin
            h_sub_nxt = '0;
            h_col_nxt = (h_col == CELL_LAST) ? 4'd0 : h_col + 1'b1;
            if ((h_col == CELL_LAST) && (h_dig != DIG_END)) begin
                h_dig_nxt = h_dig + 1'b1;
            end
        end
    end

    // vertical steps happen once per line, at x = 0
    always_comb begin
        v_sub_nxt = v_sub;
        v_row_nxt = v_row;
        if (vid.y == BOX_Y0) begin
            v_sub_nxt = '0;
            v_row_nxt = '0;
        end else if ((vid.x == '0) && (v_sub == SUB_LAST)) begin
            v_sub_nxt = '0;
            v_row_nxt = (v_row == CELL_LAST) ? 4'd0 : v_row + 1'b1;
        end else if (vid.x == '0) begin
            v_sub_nxt = v_sub + 1'b1;
        end
    end

    assign in_box = (vid.x >= BOX_X0) && (vid.x < BOX_X1) &&
                    (vid.y >= BOX_Y0) && (vid.y < BOX_Y1);

    always_comb begin
        idx_nxt = score_pkg::DIGIT_BLANK;
        for (int i = 0; i < score_pkg::NUM_DIGITS; i++) begin
            if (h_dig_nxt == DIG_W'(i)) begin
                idx_nxt = digits[i];
            end
        end
    end

    digit_glyph_rom glyph_rom_inst (
        .idx  (s1_idx),
        .row  (v_row),
        .bits (glyph_bits)
    );

    assign lit = s1_in && glyph_bits[CELL_LAST - h_col];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_sub  <= '0;
            h_col  <= '0;
            h_dig  <= '0;
            v_sub  <= '0;
            v_row  <= '0;
            s1_in  <= 1'b0;
            s1_idx <= score_pkg::DIGIT_BLANK;
            s1_de  <= 1'b0;
            s1_hs  <= 1'b0;
            s1_vs  <= 1'b0;
            de     <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            rgb    <= video_pkg::RGB_BLACK;
        end else begin
            // stage 1
            h_sub  <= h_sub_nxt;
            h_col  <= h_col_nxt;
            h_dig  <= h_dig_nxt;
            v_sub  <= v_sub_nxt;
            v_row  <= v_row_nxt;
            s1_in  <= in_box;
            s1_idx <= idx_nxt;
            s1_de  <= vid.de;
            s1_hs  <= vid.hsync;
            s1_vs  <= vid.vsync;
            // stage 2
            de     <= s1_de;
            hsync  <= s1_hs;
            vsync  <= s1_vs;
            rgb    <= !s1_de ? video_pkg::RGB_BLACK : (lit ? FG_RGB : BG_RGB);
        end
    end

    // the compare-based box and the step counters must agree
    digit_pos_in_box: assert property (
        @(posedge clk) disable iff (!arst_n) s1_in |-> (h_dig < DIG_END)
    );

endmodule

`default_nettype wire

/* source/score_display.sv */
`timescale 1ns/10ps
`default_nettype none

module score_display #(
    parameter int              H_ACTIVE = 160,
    parameter int              H_FRONT  = 8,
    parameter int              H_SYNC   = 16,
    parameter int              H_TOTAL  = 192,
    parameter int              V_ACTIVE = 40,
    parameter int              V_FRONT  = 2,
    parameter int              V_SYNC   = 2,
    parameter int              V_TOTAL  = 46,
    parameter int              ORIGIN_X = 8,
    parameter int              ORIGIN_Y = 4,
    parameter int              SCALE    = 3,
    parameter video_pkg::rgb_t FG_RGB   = 12'hF80,
    parameter video_pkg::rgb_t BG_RGB   = 12'h000
) (
    input wire                    clk,
    input wire                    arst_n,
    input wire score_pkg::score_t value,
    input wire                    load,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output video_pkg::rgb_t       rgb
);

    video_if vid ();

    logic                  frame_start;
    score_pkg::digit_vec_t digits;

    video_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_TOTAL (H_TOTAL),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_TOTAL (V_TOTAL)
    ) video_timing_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .vid    (vid)
    );

    // new digits take effect only between frames
    assign frame_start = (vid.x == '0) && (vid.y == '0);

    score_latch score_latch_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .value       (value),
        .load        (load),
        .frame_start (frame_start),
        .digits      (digits)
    );

    digit_overlay #(
        .ORIGIN_X (ORIGIN_X), .ORIGIN_Y (ORIGIN_Y), .SCALE (SCALE),
        .FG_RGB   (FG_RGB),   .BG_RGB   (BG_RGB)
    ) digit_overlay_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .vid    (vid),
        .digits (digits),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de),
        .rgb    (rgb)
    );

endmodule

`default_nettype wire

/* dv/score_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module score_display_tb;

    localparam int H_ACTIVE = 160;
    localparam int H_FRONT  = 8;
    localparam int H_SYNC   = 16;
    localparam int H_TOTAL  = 192;
    localparam int V_ACTIVE = 40;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 46;
    localparam int ORIGIN_X = 8;
    localparam int ORIGIN_Y = 4;
    localparam int SCALE    = 3;
    localparam video_pkg::rgb_t FG_RGB = 12'hF80;
    localparam video_pkg::rgb_t BG_RGB = 12'h000;

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CELL_PX      = score_pkg::GLYPH_SIZE * SCALE;
    localparam int NUM_FIXED    = 4;
    localparam int NUM_VALUES   = NUM_FIXED + 6;
    // line where the mid-frame load lands, inside the lower glyph rows
    localparam int MID_LINE     = 19;

    typedef struct packed {
        score_pkg::score_t value;
        logic [1:0]        pos;
        logic [3:0]        row;
        logic [3:0]        col;
        logic              lit;
    } probe_t;

    localparam int NUM_PROBES = 29;
    localparam probe_t PROBES [NUM_PROBES] = '{
        '{14'd1817, 2'd0, 4'd8, 4'd0, 1'b1},
        '{14'd1817, 2'd0, 4'd8, 4'd9, 1'b1},
        '{14'd1817, 2'd0, 4'd9, 4'd4, 1'b1},
        '{14'd1817, 2'd0, 4'd0, 4'd0, 1'b0},
        '{14'd1817, 2'd0, 4'd0, 4'd4, 1'b1},
        '{14'd1817, 2'd1, 4'd0, 4'd0, 1'b0},
        '{14'd1817, 2'd1, 4'd0, 4'd1, 1'b0},
        '{14'd1817, 2'd1, 4'd0, 4'd2, 1'b1},
        '{14'd1817, 2'd1, 4'd0, 4'd5, 1'b1},
        '{14'd1817, 2'd1, 4'd0, 4'd7, 1'b1},
        '{14'd1817, 2'd1, 4'd0, 4'd8, 1'b0},
        '{14'd1817, 2'd1, 4'd0, 4'd9, 1'b0},
        '{14'd1817, 2'd2, 4'd9, 4'd0, 1'b1},
        '{14'd1817, 2'd2, 4'd9, 4'd9, 1'b1},
        '{14'd1817, 2'd3, 4'd0, 4'd0, 1'b1},
        '{14'd1817, 2'd3, 4'd0, 4'd9, 1'b1},
        '{14'd1817, 2'd3, 4'd1, 4'd0, 1'b1},
        '{14'd1817, 2'd3, 4'd1, 4'd5, 1'b1},
        '{14'd1817, 2'd3, 4'd9, 4'd0, 1'b0},
        '{14'd1817, 2'd3, 4'd9, 4'd1, 1'b1},
        '{14'd7,    2'd3, 4'd0, 4'd0, 1'b1},
        '{14'd7,    2'd3, 4'd4, 4'd6, 1'b1},
        '{14'd7,    2'd0, 4'd4, 4'd4, 1'b0},
        '{14'd0,    2'd3, 4'd0, 4'd0, 1'b0},
        '{14'd0,    2'd3, 4'd0, 4'd3, 1'b1},
        '{14'd0,    2'd3, 4'd4, 4'd2, 1'b0},
        '{14'd0,    2'd3, 4'd4, 4'd4, 1'b1},
        '{14'd12000, 2'd0, 4'd8, 4'd0, 1'b0},
        '{14'd12000, 2'd1, 4'd0, 4'd3, 1'b0}
    };

    logic                  clk = 1'b0;
    logic                  arst_n;
    score_pkg::score_t     value;
    logic                  load;
    logic                  hsync;
    logic                  vsync;
    logic                  de;
    video_pkg::rgb_t       rgb;

    score_pkg::score_t     values [NUM_VALUES];
    video_pkg::coord_t     px;
    video_pkg::coord_t     ln;
    logic                  de_q;
    logic                  vs_q;
    logic                  hs_q;
    int                    hs_len;
    int                    vs_len;
    logic                  frame_end;
    logic                  scan_on;
    score_pkg::score_t     scan_value;
    int                    scan_first;
    logic [score_pkg::NUM_DIGITS-1:0] fg_seen;
    int                    probes_hit;
    int                    value_errors;
    int                    other_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    score_display #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_TOTAL (H_TOTAL),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_TOTAL (V_TOTAL),
        .ORIGIN_X (ORIGIN_X), .ORIGIN_Y (ORIGIN_Y), .SCALE (SCALE),
        .FG_RGB   (FG_RGB),   .BG_RGB   (BG_RGB)
    ) score_display_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .value  (value),
        .load   (load),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de),
        .rgb    (rgb)
    );

    task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
                             input video_pkg::rgb_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input video_pkg::coord_t exp,
                               input video_pkg::coord_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // leading zeros and overrange values draw nothing
    function automatic logic digit_blank(input score_pkg::score_t v, input int pos);
        int place;
        place = 1;
        for (int k = pos; k < score_pkg::NUM_DIGITS - 1; k++) begin
            place = place * 10;
        end
        if (int'(v) > score_pkg::SCORE_MAX) begin
            return 1'b1;
        end
        return (pos < score_pkg::NUM_DIGITS - 1) && ((int'(v) / place) == 0);
    endfunction

    task automatic build_table();
        logic [31:0] rng;
        rng = 32'd30092;
        values[0] = 14'd1817;
        values[1] = 14'd7;
        values[2] = 14'd0;
        values[3] = 14'd12000;
        for (int i = NUM_FIXED; i < NUM_VALUES; i++) begin
            rng = xorshift32(rng);
            values[i] = rng[13:0];
        end
    endtask

    task automatic check_pixel();
        int    dx;
        int    dy;
        int    pos;
        int    row;
        int    col;
        string name;
        dx = int'(px) - ORIGIN_X;
        dy = int'(ln) - ORIGIN_Y;
        if ((dx < 0) || (dx >= score_pkg::NUM_DIGITS * CELL_PX) ||
            (dy < 0) || (dy >= CELL_PX)) begin
            check_rgb("pixel outside the digit box", BG_RGB, rgb);
        end else begin
            pos = dx / CELL_PX;
            col = (dx % CELL_PX) / SCALE;
            row = dy / SCALE;
            if (rgb == FG_RGB) begin
                fg_seen[pos] = 1'b1;
            end else if (rgb != BG_RGB) begin
                other_errors++;
                $display("pixel %0d on line %0d has a color that is neither fg nor bg", px, ln);
            end
            // probes are taken at the center pixel of a glyph cell
            if (((dx % SCALE) == SCALE / 2) && ((dy % SCALE) == SCALE / 2)) begin
                for (int i = 0; i < NUM_PROBES; i++) begin
                    if ((PROBES[i].value == scan_value) && (int'(PROBES[i].pos) == pos) &&
                        (int'(PROBES[i].row) == row) && (int'(PROBES[i].col) == col)) begin
                        name = $sformatf("value %0d digit %0d cell row %0d col %0d",
                                         scan_value, pos, row, col);
                        check_rgb(name, PROBES[i].lit ? FG_RGB : BG_RGB, rgb);
                        probes_hit++;
                    end
                end
            end
        end
    endtask

    // one clock of output sampling with the raster checks
    task automatic step();
        @(negedge clk);
        frame_end = 1'b0;
        if (hsync && de) begin
            other_errors++;
            $display("hsync is high while de is high on line %0d", ln);
        end
        if (de) begin
            px = (!de_q) ? '0 : px + 1'b1;
            if (scan_on && (int'(ln) >= scan_first)) begin
                check_pixel();
            end
        end else begin
            check_rgb("rgb during blanking", video_pkg::RGB_BLACK, rgb);
            if (de_q) begin
                check_count("pixels per line", video_pkg::coord_t'(H_ACTIVE), px + 1'b1);
                ln = ln + 1'b1;
            end
        end
        if (hsync) begin
            hs_len++;
        end else if (hs_q) begin
            check_count("hsync pulse width", video_pkg::coord_t'(H_SYNC),
                        video_pkg::coord_t'(hs_len));
            hs_len = 0;
        end
        if (vsync) begin
            vs_len++;
        end
        if (vs_q && !vsync) begin
            check_count("lines per frame", video_pkg::coord_t'(V_ACTIVE), ln);
            check_count("vsync length in clocks", video_pkg::coord_t'(V_SYNC * H_TOTAL),
                        video_pkg::coord_t'(vs_len));
            vs_len = 0;
            ln = '0;
            frame_end = 1'b1;
        end
        de_q = de;
        vs_q = vsync;
        hs_q = hsync;
    endtask

    task automatic wait_frames(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            step();
            if (frame_end) begin
                seen++;
            end
        end
    endtask

    task automatic load_score(input score_pkg::score_t v);
        step();
        value = v;
        load  = 1'b1;
        step();
        load  = 1'b0;
    endtask

    task automatic scan_frame(input score_pkg::score_t v, input int first_line,
                              input int load_line, input score_pkg::score_t load_value);
        int expected_hits;
        expected_hits = 0;
        for (int i = 0; i < NUM_PROBES; i++) begin
            if ((PROBES[i].value == v) &&
                (ORIGIN_Y + int'(PROBES[i].row) * SCALE + SCALE / 2 >= first_line)) begin
                expected_hits++;
            end
        end
        scan_value = v;
        scan_first = first_line;
        fg_seen    = '0;
        probes_hit = 0;
        scan_on    = 1'b1;
        do begin
            step();
            load = 1'b0;
            if (de && (px == '0) && (int'(ln) == load_line)) begin
                value = load_value;
                load  = 1'b1;
            end
        end while (!frame_end);
        scan_on = 1'b0;
        check_count($sformatf("probes sampled for value %0d", v),
                    video_pkg::coord_t'(expected_hits), video_pkg::coord_t'(probes_hit));
        for (int k = 0; k < score_pkg::NUM_DIGITS; k++) begin
            if (digit_blank(v, k) && fg_seen[k]) begin
                other_errors++;
                $display("value %0d lights digit %0d which should be blank", v, k);
            end else if (!digit_blank(v, k) && !fg_seen[k]) begin
                other_errors++;
                $display("value %0d shows nothing at digit %0d", v, k);
            end
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        value        = '0;
        load         = 1'b0;
        px           = '0;
        ln           = '0;
        de_q         = 1'b0;
        vs_q         = 1'b0;
        hs_q         = 1'b0;
        hs_len       = 0;
        vs_len       = 0;
        frame_end    = 1'b0;
        scan_on      = 1'b0;
        scan_value   = '0;
        scan_first   = 0;
        fg_seen      = '0;
        probes_hit   = 0;
        value_errors = 0;
        other_errors = 0;
        build_table();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        wait_frames(1);

        for (int t = 0; t < NUM_VALUES; t++) begin
            load_score(values[t]);
            wait_frames(2);
            scan_frame(values[t], 0, -1, '0);
        end

        // a load in mid frame must not change the rest of that frame
        load_score(14'd1817);
        wait_frames(2);
        scan_frame(14'd1817, MID_LINE, MID_LINE, 14'd7);
        scan_frame(14'd7, 0, -1, '0);

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((NUM_VALUES + 4) * 3 * FRAME_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/video_pkg.sv
source/score_pkg.sv
source/video_if.sv
source/video_timing.sv
source/score_latch.sv
source/digit_glyph_rom.sv
source/digit_overlay.sv
source/score_display.sv
dv/score_display_tb.sv

/* build.sh */
#!/bin/sh
# compile and run the score overlay testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module score_display_tb \
    -f project.f \
    -o score_display_sim

./obj_dir/score_display_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
